/* design/ifu_pkg.sv */
package ifu_pkg;

   // ******************************
   // address and payload types
   // ******************************
   typedef logic [31:1] pc_t;             // halfword instruction address
   typedef logic [15:0] halfword_t;       // one instruction parcel
   typedef logic [31:0] instr_t;          // to decode, 2-byte kind has upper half zero
   typedef logic [63:0] fetch_blk_t;      // four parcels, lowest address in [15:0]
   typedef logic [31:3] blk_addr_t;       // 8-byte block address

   localparam int BLK_HW = 4;             // parcels per fetch block

   // ******************************
   // icache entries
   // ******************************
   // full block address kept in the tag
   // so the line count can change freely
   typedef struct packed {
      logic      valid;                   // line filled
      blk_addr_t blk;                     // block held by the line
   } ic_tag_t;

   // ******************************
   // axi read channel
   // ******************************
   typedef logic [1:0] axi_resp_t;        // rresp encoding
   localparam axi_resp_t AXI_OKAY = 2'b00;   // only good response

endpackage

/* design/ifu_ic_array.sv */
`timescale 1ns/1ns

module ifu_ic_array #(
   parameter int  depth   = 16,           // lines, power of two
   parameter type entry_t = logic         // tag or data entry
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     rd_en,      // lookup this cycle
   input  logic [$clog2(depth)-1:0] rd_idx,
   output entry_t                   rd_entry,   // valid one cycle after rd_en
   input  logic                     wr_en,      // fill
   input  logic [$clog2(depth)-1:0] wr_idx,
   input  entry_t                   wr_entry
);

   entry_t mem [depth];                   // storage, one entry per line

   // write port, reset wipes every line
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;                 // clears tag valid bits
         end
      end else if (wr_en) begin
         mem[wr_idx] <= wr_entry;
      end
   end

   // registered read, holds when idle
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_entry <= mem[rd_idx];
      end
   end

endmodule

/* design/ifu_ifc_ctl.sv */
`timescale 1ns/1ns

module ifu_ifc_ctl #(
   parameter logic [31:0] reset_pc = 32'h0000_0000   // byte address of first fetch
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         exu_flush_final,        // redirect request
   input  ifu_pkg::pc_t exu_flush_path_final,   // redirect target
   input  logic [1:0]   aln_free,               // empty aligner slots
   input  logic         fetch_ack,              // request taken by mem ctl
   input  logic         blk_valid,              // block delivered to aligner
   output logic         fetch_req,              // ask for the block at fetch_addr
   output ifu_pkg::pc_t fetch_addr              // current fetch pc
);

   logic [1:0]         in_flight;               // acked blocks not yet back
   ifu_pkg::blk_addr_t next_blk;                // block following fetch_addr

   assign next_blk = fetch_addr[31:3] + 29'd1;

   // ******************************
   // request pacing
   // ******************************
   // each acked block already owns a free slot
   assign fetch_req = ~exu_flush_final & (in_flight < aln_free);   // no stale req on redirect

   always_ff @(posedge clk) begin
      if (rst) begin
         in_flight <= 2'd0;
      end else if (exu_flush_final) begin
         in_flight <= 2'd0;                     // mem ctl drops pending returns
      end else begin
         in_flight <= in_flight + {1'b0, fetch_ack} - {1'b0, blk_valid};
      end
   end

   // ******************************
   // fetch address
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_addr <= reset_pc[31:1];          // halfword part of start address
      end else if (exu_flush_final) begin
         fetch_addr <= exu_flush_path_final;    // may land mid block
      end else if (fetch_ack) begin
         fetch_addr <= {next_blk, 2'b00};       // sequential, block aligned
      end
   end

endmodule

/* design/ifu_mem_ctl.sv */
`timescale 1ns/1ns

module ifu_mem_ctl #(
   parameter int ic_lines = 16                  // direct mapped lines
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                exu_flush_final,     // discard unreturned block
   input  logic                fetch_req,
   input  ifu_pkg::pc_t        fetch_addr,
   output logic                fetch_ack,           // request accepted this cycle
   output logic                blk_valid,           // block to aligner
   output ifu_pkg::pc_t        blk_pc,              // pc that was requested
   output ifu_pkg::fetch_blk_t blk_data,
   output logic                blk_fault,           // bus error on fill
   output logic                ifu_axi_arvalid,
   input  logic                ifu_axi_arready,
   output logic [31:0]         ifu_axi_araddr,
   input  logic                ifu_axi_rvalid,
   output logic                ifu_axi_rready,
   input  logic [63:0]         ifu_axi_rdata,
   input  ifu_pkg::axi_resp_t  ifu_axi_rresp,
   output logic                ifu_miss_state_idle  // no read outstanding
);

   localparam int idx_w = $clog2(ic_lines);     // line index bits

   typedef enum logic [1:0] {
      miss_idle,                                // lookups allowed
      miss_addr,                                // ar waiting for arready
      miss_data                                 // waiting for r beat
   } miss_state_t;

   miss_state_t         miss_state;
   miss_state_t         miss_state_nxt;
   logic                lk_vld;                 // compare cycle of a lookup
   ifu_pkg::pc_t        lk_pc;                  // looked up pc, held over a miss
   ifu_pkg::ic_tag_t    tag_rd;
   ifu_pkg::ic_tag_t    tag_wr;
   ifu_pkg::fetch_blk_t data_rd;
   logic                tag_hit;
   logic                hit_ret;                // hit block goes out now
   logic                miss_start;             // lookup missed, go to bus
   logic                r_take;                 // r beat accepted
   logic                fill_ok;                // write both arrays
   logic                miss_drop;              // redirect seen during miss
   logic                fill_ret;               // filled block goes out now
   logic                fill_fault;
   ifu_pkg::fetch_blk_t fill_data;

   // ******************************
   // lookup
   // ******************************
   assign fetch_ack = fetch_req & (miss_state == miss_idle) & ~miss_start;   // idle or hitting

   always_ff @(posedge clk) begin
      if (rst) begin
         lk_vld <= 1'b0;
      end else begin
         lk_vld <= fetch_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_ack) begin
         lk_pc <= fetch_addr;
      end
   end

   ifu_ic_array #(
      .depth   (ic_lines),
      .entry_t (ifu_pkg::ic_tag_t)
   ) i_tag_array (
      .clk      (clk),
      .rst      (rst),
      .rd_en    (fetch_ack),
      .rd_idx   (fetch_addr[3 +: idx_w]),
      .rd_entry (tag_rd),
      .wr_en    (fill_ok),
      .wr_idx   (lk_pc[3 +: idx_w]),
      .wr_entry (tag_wr)
   );

   ifu_ic_array #(
      .depth   (ic_lines),
      .entry_t (ifu_pkg::fetch_blk_t)
   ) i_data_array (
      .clk      (clk),
      .rst      (rst),
      .rd_en    (fetch_ack),
      .rd_idx   (fetch_addr[3 +: idx_w]),
      .rd_entry (data_rd),
      .wr_en    (fill_ok),
      .wr_idx   (lk_pc[3 +: idx_w]),
      .wr_entry (ifu_axi_rdata)
   );

   assign tag_hit    = tag_rd.valid & (tag_rd.blk == lk_pc[31:3]);
   assign hit_ret    = lk_vld & tag_hit;
   assign miss_start = lk_vld & ~tag_hit;
   assign tag_wr.valid = 1'b1;
   assign tag_wr.blk   = lk_pc[31:3];

   // ******************************
   // miss fsm and axi read
   // ******************************
   always_comb begin
      miss_state_nxt = miss_state;
      case (miss_state)
         miss_idle: begin
            if (miss_start) begin
               miss_state_nxt = ifu_axi_arready ? miss_data : miss_addr;   // ar may go at once
            end
         end
         miss_addr: begin
            if (ifu_axi_arready) begin
               miss_state_nxt = miss_data;
            end
         end
         miss_data: begin
            if (ifu_axi_rvalid) begin
               miss_state_nxt = miss_idle;
            end
         end
         default: miss_state_nxt = miss_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         miss_state <= miss_idle;
      end else begin
         miss_state <= miss_state_nxt;
      end
   end

   assign ifu_axi_arvalid     = miss_start | (miss_state == miss_addr);   // rises on compare cycle
   assign ifu_axi_araddr      = {lk_pc[31:3], 3'b000};                   // stable, lk_pc held
   assign ifu_axi_rready      = (miss_state == miss_data);
   assign ifu_miss_state_idle = (miss_state == miss_idle);

   assign r_take  = ifu_axi_rvalid & ifu_axi_rready;
   assign fill_ok = r_take & (ifu_axi_rresp == ifu_pkg::AXI_OKAY);   // errors never cached

   // read always finishes, only the return is killed
   always_ff @(posedge clk) begin
      if (rst) begin
         miss_drop <= 1'b0;
      end else if (miss_start) begin
         miss_drop <= exu_flush_final;
      end else if (exu_flush_final) begin
         miss_drop <= 1'b1;
      end
   end

   // ******************************
   // block return
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fill_ret <= 1'b0;
      end else begin
         fill_ret <= r_take;                    // cycle after the beat
      end
   end

   always_ff @(posedge clk) begin
      if (r_take) begin
         fill_data  <= ifu_axi_rdata;
         fill_fault <= (ifu_axi_rresp != ifu_pkg::AXI_OKAY);
      end
   end

   assign blk_valid = (hit_ret | (fill_ret & ~miss_drop)) & ~exu_flush_final;
   assign blk_pc    = lk_pc;
   assign blk_data  = fill_ret ? fill_data : data_rd;   // never both in one cycle
   assign blk_fault = fill_ret & fill_fault;

endmodule

/* design/ifu_aln_ctl.sv */
`timescale 1ns/1ns

module ifu_aln_ctl (
   input  logic                clk,
   input  logic                rst,
   input  logic                exu_flush_final,   // empties the buffer
   input  logic                blk_valid,
   input  ifu_pkg::pc_t        blk_pc,
   input  ifu_pkg::fetch_blk_t blk_data,
   input  logic                blk_fault,
   output logic [1:0]          aln_free,          // free entries, 0 to 2
   input  logic                dec_ready,
   output logic                ifu_i0_valid,
   output ifu_pkg::pc_t        ifu_i0_pc,
   output ifu_pkg::instr_t     ifu_i0_instr,
   output logic                ifu_i0_pc4,        // 4-byte instruction
   output logic                ifu_i0_icaf        // access fault
);

   localparam int hw_w = $clog2(ifu_pkg::BLK_HW);   // parcel pointer bits

   ifu_pkg::fetch_blk_t buf_data [2];           // block entries
   ifu_pkg::blk_addr_t  buf_blk  [2];
   logic [1:0]          buf_fault;
   logic [1:0]          buf_vld;
   logic                hd;                     // oldest entry
   logic                tl;                     // where the next block lands
   logic                nx;                     // entry holding the upper parcel
   logic [hw_w-1:0]     rp;                     // parcel pointer in head block
   logic [hw_w-1:0]     rp_inc;
   logic [hw_w:0]       rp_sum;                 // carry out frees the head
   ifu_pkg::halfword_t  parcel0;
   ifu_pkg::halfword_t  parcel1;
   logic                straddle;               // pointer at last parcel
   logic                is4;
   logic                avail;                  // whole instruction present
   logic                issue;                  // load output register
   logic                head_done;
   logic                blk_wr;
   logic                icaf_nxt;

   // ******************************
   // buffer bookkeeping
   // ******************************
   assign tl       = buf_vld[hd] ? ~hd : hd;
   assign blk_wr   = blk_valid & ~exu_flush_final;
   assign aln_free = 2'd2 - ({1'b0, buf_vld[0]} + {1'b0, buf_vld[1]});

   always_ff @(posedge clk) begin
      if (rst) begin
         buf_vld <= 2'b00;
         hd      <= 1'b0;
      end else if (exu_flush_final) begin
         buf_vld <= 2'b00;                      // older stream is gone
         hd      <= 1'b0;
      end else begin
         if (head_done) begin
            buf_vld[hd] <= 1'b0;
            hd          <= ~hd;
         end
         if (blk_wr) begin
            buf_vld[tl] <= 1'b1;                // tl never equals a freed head
         end
      end
   end

   always_ff @(posedge clk) begin
      if (blk_wr) begin
         buf_data[tl]  <= blk_data;
         buf_blk[tl]   <= blk_pc[31:3];
         buf_fault[tl] <= blk_fault;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rp <= '0;
      end else if (blk_wr & ~|buf_vld) begin
         rp <= blk_pc[2:1];                     // first block after redirect
      end else if (issue) begin
         rp <= rp_sum[hw_w-1:0];                // wraps into the next block
      end
   end

   // ******************************
   // instruction extraction
   // ******************************
   assign straddle = &rp;
   assign rp_inc   = rp + 1'b1;
   assign nx       = straddle ? ~hd : hd;
   assign parcel0  = buf_data[hd][16*rp +: 16];
   assign parcel1  = buf_data[nx][16*rp_inc +: 16];

   assign is4      = (parcel0[1:0] == 2'b11) & ~buf_fault[hd];   // faulted parcel is 2-byte
   assign avail    = buf_vld[hd] & (~(is4 & straddle) | buf_vld[~hd]);
   assign issue    = avail & (~ifu_i0_valid | dec_ready) & ~exu_flush_final;
   assign rp_sum   = {1'b0, rp} + 1'b1 + is4;
   assign head_done = issue & rp_sum[hw_w];
   assign icaf_nxt = buf_fault[hd] | (is4 & straddle & buf_fault[~hd]);

   // ******************************
   // decode output register
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         ifu_i0_valid <= 1'b0;
      end else if (exu_flush_final) begin
         ifu_i0_valid <= 1'b0;
      end else if (issue) begin
         ifu_i0_valid <= 1'b1;
      end else if (dec_ready) begin
         ifu_i0_valid <= 1'b0;                  // taken, nothing behind it
      end
   end

   // fields move only on issue so they hold under back-pressure
   always_ff @(posedge clk) begin
      if (issue) begin
         ifu_i0_pc   <= {buf_blk[hd], rp};
         ifu_i0_pc4  <= is4;
         ifu_i0_icaf <= icaf_nxt;
         if (icaf_nxt) begin
            ifu_i0_instr <= '0;
         end else if (is4) begin
            ifu_i0_instr <= {parcel1, parcel0};
         end else begin
            ifu_i0_instr <= {16'h0000, parcel0};
         end
      end
   end

endmodule

/* design/ifu.sv */
`timescale 1ns/1ns

module ifu #(
   parameter int          ic_lines = 16,             // icache lines
   parameter logic [31:0] reset_pc = 32'h0000_0000   // fetch start after reset
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         exu_flush_final,       // redirect
   input  ifu_pkg::pc_t exu_flush_path_final,  // redirect target
   input  logic         dec_ready,             // decode takes i0

   output logic         ifu_i0_valid,
   output logic [31:1]  ifu_i0_pc,
   output logic [31:0]  ifu_i0_instr,
   output logic         ifu_i0_pc4,
   output logic         ifu_i0_icaf,

   output logic         ifu_axi_arvalid,
   input  logic         ifu_axi_arready,
   output logic [31:0]  ifu_axi_araddr,
   input  logic         ifu_axi_rvalid,
   output logic         ifu_axi_rready,
   input  logic [63:0]  ifu_axi_rdata,
   input  logic [1:0]   ifu_axi_rresp,

   output logic         ifu_miss_state_idle    // no miss outstanding
);

   logic                fetch_req;             // ifc to mem ctl
   ifu_pkg::pc_t        fetch_addr;
   logic                fetch_ack;             // mem ctl to ifc
   logic                blk_valid;             // mem ctl to aligner and ifc
   ifu_pkg::pc_t        blk_pc;
   ifu_pkg::fetch_blk_t blk_data;
   logic                blk_fault;
   logic [1:0]          aln_free;              // aligner to ifc pacing

   // ******************************
   // fetch address and pacing
   // ******************************
   ifu_ifc_ctl #(
      .reset_pc (reset_pc)
   ) i_ifc_ctl (.*);

   // ******************************
   // icache and axi miss path
   // ******************************
   ifu_mem_ctl #(
      .ic_lines (ic_lines)
   ) i_mem_ctl (.*);

   // ******************************
   // aligner toward decode
   // ******************************
   ifu_aln_ctl i_aln_ctl (.*);

endmodule

/* tb/ifu_sva.sv */
`timescale 1ns/1ns

module ifu_sva (
   input logic        clk,
   input logic        rst,
   input logic        exu_flush_final,
   input logic        dec_ready,
   input logic        ifu_i0_valid,
   input logic [31:1] ifu_i0_pc,
   input logic [31:0] ifu_i0_instr,
   input logic        ifu_i0_pc4,
   input logic        ifu_i0_icaf,
   input logic        ifu_axi_arvalid,
   input logic        ifu_axi_arready,
   input logic [31:0] ifu_axi_araddr
);

   // ar channel holds until the slave takes it
   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      ifu_axi_arvalid && !ifu_axi_arready |=> ifu_axi_arvalid && $stable(ifu_axi_araddr))
      else $error("ar channel changed before arready");

   // decode fields frozen under back-pressure
   a_i0_hold: assert property (@(posedge clk) disable iff (rst)
      ifu_i0_valid && !dec_ready && !exu_flush_final |=>
         ifu_i0_valid && $stable(ifu_i0_pc) && $stable(ifu_i0_instr) &&
         $stable(ifu_i0_pc4) && $stable(ifu_i0_icaf))
      else $error("i0 changed while decode stalled");

   // quiet outputs while in reset
   a_rst_quiet: assert property (@(posedge clk)
      rst |=> !ifu_i0_valid && !ifu_axi_arvalid)
      else $error("i0 valid or arvalid high during reset");

endmodule

bind ifu ifu_sva i_sva (.*);

/* tb/ifu_tb_ref.svh */
// ******************************
// memory image and reference model
// ******************************

// parcel at byte address a: upper bits ~a[15:2], low bits pick the length
function automatic logic [15:0] mem_hw(input logic [31:0] a);
   logic [1:0] lo;
   lo = (a[2] == a[4]) ? 2'b11 : 2'b01;     // 11 starts a 4-byte instr
   return {~a[15:2], lo};
endfunction

function automatic logic fault_page(input logic [31:0] a);
   return (a >= 32'h2000) && (a < 32'h3000);   // bus error window
endfunction

// one 8-byte beat, lowest address in the low bits
function automatic logic [63:0] mem_blk(input logic [31:0] a);
   return {mem_hw(a + 6), mem_hw(a + 4), mem_hw(a + 2), mem_hw(a)};
endfunction

// one decode transfer starting at pc, and the pc after it
function automatic void ref_step(input logic [31:0] pc, output logic [31:0] instr,
                                 output logic pc4, output logic icaf,
                                 output logic [31:0] nxt);
   logic [15:0] p0;
   p0   = mem_hw(pc);
   icaf = fault_page(pc);
   pc4  = ~icaf & (p0[1:0] == 2'b11);
   if (icaf) begin
      instr = 32'h0;                        // faulted parcel carries nothing
      nxt   = pc + 2;
   end else if (pc4) begin
      instr = {mem_hw(pc + 2), p0};
      nxt   = pc + 4;
   end else begin
      instr = {16'h0000, p0};
      nxt   = pc + 2;
   end
endfunction

/* tb/ifu_checker.sv */
`timescale 1ns/1ns

module ifu_checker #(
   parameter logic [31:0] reset_pc = 32'h0000_0100   // first expected pc
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        flush,              // exu_flush_final
   input  logic [31:1] flush_path,
   input  logic        dec_ready,
   input  logic        valid,              // ifu_i0_valid
   input  logic [31:1] pc,
   input  logic [31:0] instr,
   input  logic        pc4,
   input  logic        icaf,
   input  logic        arvalid,
   input  logic        arready,
   input  logic [31:0] araddr,
   input  logic        rvalid,
   input  logic        rready,
   input  logic        miss_idle,          // ifu_miss_state_idle
   output int          xfer_cnt,           // accepted transfers
   output int          err_cnt
);

`include "ifu_tb_ref.svh"

   logic [31:0] exp_pc;                    // byte pc of next expected transfer
   logic        held;                      // stalled last cycle
   logic [31:0] h_pc;
   logic [31:0] h_instr;
   logic        h_pc4;
   logic        h_icaf;
   logic        ar_done;                   // ar taken, r beat still due
   logic        miss_pend;                 // arvalid seen, r beat still due

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      err_cnt++;
   endtask

   initial begin
      xfer_cnt  = 0;
      err_cnt   = 0;
      held      = 1'b0;
      ar_done   = 1'b0;
      miss_pend = 1'b0;
      exp_pc    = reset_pc;
   end

   // ******************************
   // compare on every rising edge
   // ******************************
   always @(posedge clk) begin : compare
      logic [31:0] e_instr;
      logic        e_pc4;
      logic        e_icaf;
      logic [31:0] e_nxt;
      if (rst) begin
         exp_pc    = reset_pc;
         held      = 1'b0;
         ar_done   = 1'b0;
         miss_pend = 1'b0;
      end else begin
         if (arvalid && araddr[2:0] != 3'b000) begin
            report_mismatch("ifu_axi_araddr", araddr, {araddr[31:3], 3'b000});   // unaligned
         end
         // read channel state against the bus history
         if (rready != ar_done) begin
            report_mismatch("ifu_axi_rready", rready, ar_done);
         end
         if (miss_idle == miss_pend) begin
            report_mismatch("ifu_miss_state_idle", miss_idle, !miss_pend);
         end
         if (rvalid && rready) begin        // beat taken, miss over
            ar_done   = 1'b0;
            miss_pend = 1'b0;
         end
         if (arvalid) begin
            miss_pend = 1'b1;
         end
         if (arvalid && arready) begin
            ar_done = 1'b1;
         end
         if (held) begin                    // stall must freeze i0
            if (!valid) begin
               $display("i0 valid dropped while decode was stalled at %0t", $time);
               err_cnt++;
            end else begin
               if ({pc, 1'b0} != h_pc) report_mismatch("ifu_i0_pc held", {pc, 1'b0}, h_pc);
               if (instr != h_instr) report_mismatch("ifu_i0_instr held", instr, h_instr);
               if (pc4 != h_pc4) report_mismatch("ifu_i0_pc4 held", pc4, h_pc4);
               if (icaf != h_icaf) report_mismatch("ifu_i0_icaf held", icaf, h_icaf);
            end
         end
         held    = valid & ~dec_ready & ~flush;
         h_pc    = {pc, 1'b0};
         h_instr = instr;
         h_pc4   = pc4;
         h_icaf  = icaf;
         if (flush) begin
            exp_pc = {flush_path, 1'b0};    // older stream is dead
         end else if (valid && dec_ready) begin
            ref_step(exp_pc, e_instr, e_pc4, e_icaf, e_nxt);
            if ({pc, 1'b0} != exp_pc) report_mismatch("ifu_i0_pc", {pc, 1'b0}, exp_pc);
            if (instr != e_instr) report_mismatch("ifu_i0_instr", instr, e_instr);
            if (pc4 != e_pc4) report_mismatch("ifu_i0_pc4", pc4, e_pc4);
            if (icaf != e_icaf) report_mismatch("ifu_i0_icaf", icaf, e_icaf);
            exp_pc = e_nxt;                 // resync on the reference path
            xfer_cnt++;
         end
      end
   end

endmodule

/* tb/ifu_tb.sv */
`timescale 1ns/1ns

module ifu_tb;

`include "ifu_tb_ref.svh"

   localparam int total_instr = 670;      // sum of all run lengths
   localparam int n_flush     = 13;
   localparam int cycle_limit = (total_instr + 64 * n_flush) * 20;

   logic        clk;
   logic        rst;
   logic        exu_flush_final;
   logic [31:1] exu_flush_path_final;
   logic        dec_ready;
   logic        ifu_i0_valid;
   logic [31:1] ifu_i0_pc;
   logic [31:0] ifu_i0_instr;
   logic        ifu_i0_pc4;
   logic        ifu_i0_icaf;
   logic        ifu_axi_arvalid;
   logic        ifu_axi_arready;
   logic [31:0] ifu_axi_araddr;
   logic        ifu_axi_rvalid;
   logic        ifu_axi_rready;
   logic [63:0] ifu_axi_rdata;
   logic [1:0]  ifu_axi_rresp;
   logic        ifu_miss_state_idle;

   int          seed = 12;
   int          cycles;                   // timeout counter
   int          tb_err;
   int          err_base;                 // errors at test start
   int          ar_cnt;                   // ar handshakes seen
   int          ar_dly;
   int          r_dly;
   logic        pend;                     // read accepted, beat not sent
   logic [31:0] rd_addr;
   logic        stall;                    // forces decode not ready
   int          xfer_cnt;
   int          err_cnt;
   int          ar_base;
   logic [31:0] fpc;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   ifu #(
      .ic_lines (16),
      .reset_pc (32'h0000_0100)
   ) i_ifu (.*);

   ifu_checker #(
      .reset_pc (32'h0000_0100)
   ) i_checker (
      .clk        (clk),
      .rst        (rst),
      .flush      (exu_flush_final),
      .flush_path (exu_flush_path_final),
      .dec_ready  (dec_ready),
      .valid      (ifu_i0_valid),
      .pc         (ifu_i0_pc),
      .instr      (ifu_i0_instr),
      .pc4        (ifu_i0_pc4),
      .icaf       (ifu_i0_icaf),
      .arvalid    (ifu_axi_arvalid),
      .arready    (ifu_axi_arready),
      .araddr     (ifu_axi_araddr),
      .rvalid     (ifu_axi_rvalid),
      .rready     (ifu_axi_rready),
      .miss_idle  (ifu_miss_state_idle),
      .xfer_cnt   (xfer_cnt),
      .err_cnt    (err_cnt)
   );

   // ******************************
   // axi memory model
   // ******************************
   always @(negedge clk) begin
      if (rst) begin
         ifu_axi_arready = 1'b0;
         ifu_axi_rvalid  = 1'b0;
         pend            = 1'b0;
         ar_dly          = $unsigned($random(seed)) % 8;
      end else begin
         if (ifu_axi_rvalid) begin         // beat taken at last edge
            ifu_axi_rvalid = 1'b0;
            pend           = 1'b0;
         end else if (pend) begin
            if (r_dly == 0) begin
               ifu_axi_rvalid = 1'b1;
               ifu_axi_rdata  = fault_page(rd_addr) ? 64'h0 : mem_blk(rd_addr);
               ifu_axi_rresp  = fault_page(rd_addr) ? 2'b10 : 2'b00;   // slverr in fault page
            end else begin
               r_dly--;
            end
         end
         if (ifu_axi_arready) begin        // ar handshake at last edge
            ifu_axi_arready = 1'b0;
            pend            = 1'b1;
            rd_addr         = ifu_axi_araddr;
            ar_cnt++;
            r_dly           = $unsigned($random(seed)) % 8;
            ar_dly          = $unsigned($random(seed)) % 8;
         end else if (ifu_axi_arvalid && !pend) begin
            if (ar_dly == 0) ifu_axi_arready = 1'b1;
            else ar_dly--;
         end
      end
   end

   // decode ready, about 70 % high
   always @(negedge clk) begin
      dec_ready = ~stall & (($unsigned($random(seed)) % 10) < 7);
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, instruction stream stopped", cycles);
         $display("test failed");
         $finish;
      end
   end

   // ******************************
   // stimulus tasks
   // ******************************
   task automatic flush_to(input logic [31:0] addr);
      @(negedge clk);
      exu_flush_final      = 1'b1;
      exu_flush_path_final = addr[31:1];
      @(negedge clk);
      exu_flush_final      = 1'b0;
   endtask

   task automatic run_instr(input int n);
      int target;
      target = xfer_cnt + n;
      while (xfer_cnt < target) @(negedge clk);
   endtask

   task automatic stall_cycles(input int n);
      stall = 1'b1;
      repeat (n) @(negedge clk);
      stall = 1'b0;
   endtask

   task automatic end_test(input int num, input string name);
      int errs;
      errs = err_cnt + tb_err - err_base;
      $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "bad", errs);
      err_base = err_cnt + tb_err;
   endtask

   task automatic wait_miss_idle();
      repeat (2) @(negedge clk);
      while (!ifu_miss_state_idle) @(negedge clk);
   endtask

   // ******************************
   // test sequence
   // ******************************
   initial begin
      rst                  = 1'b1;
      exu_flush_final      = 1'b0;
      exu_flush_path_final = '0;
      dec_ready            = 1'b0;
      ifu_axi_arready      = 1'b0;
      ifu_axi_rvalid       = 1'b0;
      ifu_axi_rdata        = '0;
      ifu_axi_rresp        = 2'b00;
      stall                = 1'b0;
      cycles               = 0;
      tb_err               = 0;
      err_base             = 0;
      ar_cnt               = 0;
      pend                 = 1'b0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      run_instr(200);                     // straight line from reset pc
      end_test(1, "reset stream");

      repeat (6) begin
         fpc = 32'h400 + (($unsigned($random(seed)) % 32'h800) & 32'hffff_fffe);
         flush_to(fpc);
         run_instr(30);
      end
      end_test(2, "random flushes");

      repeat (4) begin                    // long stalls fill the buffer
         stall_cycles(16);
         run_instr(10);
      end
      end_test(3, "back-pressure");

      flush_to(32'h100);
      run_instr(40);                      // first pass fills the cache
      for (int p = 2; p <= 5; p++) begin
         flush_to(32'h100);
         wait_miss_idle();
         ar_base = ar_cnt;
         run_instr(40);
         if (ar_cnt != ar_base) begin
            $display("cached pass %0d issued %0d axi reads", p, ar_cnt - ar_base);
            tb_err++;
         end
      end
      end_test(4, "cached loop");

      flush_to(32'h2000);
      run_instr(20);                      // every parcel faulted
      flush_to(32'h300);
      run_instr(30);
      end_test(5, "fault page");

      $display("instructions %0d, axi reads %0d, errors %0d",
               xfer_cnt, ar_cnt, err_cnt + tb_err);
      if (err_cnt + tb_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+tb
design/ifu_pkg.sv
design/ifu_ic_array.sv
design/ifu_ifc_ctl.sv
design/ifu_mem_ctl.sv
design/ifu_aln_ctl.sv
design/ifu.sv
tb/ifu_sva.sv
tb/ifu_checker.sv
tb/ifu_tb.sv
